/* hw/spi_settings.svh */
`ifndef SPI_SETTINGS_SVH
`define SPI_SETTINGS_SVH

// APB register address width, four registers
`define SPI_ADDR_W 2

// Register and shift width
`define SPI_DATA_W 8

// Baud divider after reset, half-period of two clocks
`define SPI_DIV_RESET 8'd1

`endif

/* hw/spi_pkg.sv */
`include "spi_settings.svh"
`default_nettype none

package spi_pkg;

    typedef enum logic [`SPI_ADDR_W-1:0] {
        REG_BAUD   = 2'd0,
        REG_RXDATA = 2'd1,
        REG_TXDATA = 2'd2,
        REG_CTRL   = 2'd3
    } spi_reg_addr_e;

    typedef logic [`SPI_DATA_W-1:0] spi_byte_t;

    // Control register as written
    typedef struct packed {
        logic [5:0] unused;
        logic       lsb_first;
        logic       cs_en;
    } spi_ctrl_t;

    // Same address as read back
    typedef struct packed {
        logic       busy;
        logic [4:0] reserved;   // Always 0
        logic       lsb_first;
        logic       cs_en;
    } spi_status_t;

    typedef union packed {
        spi_ctrl_t   ctrl;
        spi_status_t status;
    } spi_ctrl_word_u;

endpackage

`default_nettype wire

/* hw/spi_apb_regs.sv */
`include "spi_settings.svh"
`default_nettype none

module spi_apb_regs (
    input  wire                         i_clk,
    input  wire                         i_rst,

    input  wire                         i_psel,
    input  wire                         i_penable,
    input  wire                         i_pwrite,
    input  wire spi_pkg::spi_reg_addr_e i_paddr,
    input  wire spi_pkg::spi_byte_t     i_pwdata,
    output spi_pkg::spi_byte_t          o_prdata,
    output logic                        o_pready,
    output logic                        o_pslverr,

    input  wire                         i_busy,
    input  wire                         i_done,
    input  wire spi_pkg::spi_byte_t     i_rx_byte,

    output logic                        o_start,
    output spi_pkg::spi_byte_t          o_tx_byte,
    output spi_pkg::spi_byte_t          o_baud,
    output logic                        o_lsb_first,
    output logic                        o_cs_n
);

    import spi_pkg::*;

    spi_byte_t      r_baud;
    spi_byte_t      r_tx;
    spi_byte_t      r_rx;
    logic           r_cs_en;
    logic           r_lsb_first;
    logic           r_start;

    logic           busy_any;
    logic           access;
    logic           wr_txdata;
    logic           xfer_done;
    spi_ctrl_word_u wr_word;
    spi_ctrl_word_u rd_word;

    // Start pulse counts as busy so a quick second write still waits
    assign busy_any  = i_busy | r_start;

    assign access    = i_psel & i_penable;
    assign wr_txdata = access & i_pwrite & (i_paddr == REG_TXDATA);

    assign o_pready  = ~(wr_txdata & busy_any);   // Wait states until engine idle
    assign o_pslverr = access & i_pwrite & (i_paddr == REG_RXDATA);
    assign xfer_done = access & o_pready;

    assign wr_word   = i_pwdata;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_baud      <= `SPI_DIV_RESET;
            r_tx        <= '0;
            r_cs_en     <= 1'b0;
            r_lsb_first <= 1'b0;
            r_start     <= 1'b0;
        end else begin
            r_start <= 1'b0;
            if (xfer_done && i_pwrite) begin
                case (i_paddr)
                    REG_BAUD: r_baud <= i_pwdata;
                    REG_TXDATA: begin
                        r_tx    <= i_pwdata;
                        r_start <= 1'b1;   // Kick engine next cycle
                    end
                    REG_CTRL: begin
                        r_cs_en     <= wr_word.ctrl.cs_en;
                        r_lsb_first <= wr_word.ctrl.lsb_first;
                    end
                    default: ;   // RXDATA read only, error response
                endcase
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_rx <= '0;
        end else if (i_done) begin
            r_rx <= i_rx_byte;   // Byte from finished transfer
        end
    end

    always_comb begin
        rd_word                  = '0;
        rd_word.status.busy      = busy_any;
        rd_word.status.lsb_first = r_lsb_first;
        rd_word.status.cs_en     = r_cs_en;
    end

    always_comb begin
        case (i_paddr)
            REG_BAUD:   o_prdata = r_baud;
            REG_RXDATA: o_prdata = r_rx;
            REG_TXDATA: o_prdata = r_tx;
            default:    o_prdata = rd_word;   // Status view
        endcase
    end

    assign o_start     = r_start;
    assign o_tx_byte   = r_tx;
    assign o_baud      = r_baud;
    assign o_lsb_first = r_lsb_first;
    assign o_cs_n      = ~r_cs_en;

endmodule

`default_nettype wire

/* hw/spi_clk_div.sv */
`include "spi_settings.svh"
`default_nettype none

module spi_clk_div (
    input  wire                     i_clk,
    input  wire                     i_rst,
    input  wire                     i_en,
    input  wire                     i_start,
    input  wire spi_pkg::spi_byte_t i_baud,
    output logic                    o_tick
);

    import spi_pkg::*;

    spi_byte_t r_div;
    spi_byte_t r_cnt;

    // Baud sampled once per transfer
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_div <= `SPI_DIV_RESET;
        end else if (i_start) begin
            r_div <= i_baud;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst || !i_en) begin
            r_cnt <= '0;   // Idle between transfers
        end else if (o_tick) begin
            r_cnt <= '0;
        end else begin
            r_cnt <= r_cnt + 1'b1;
        end
    end

    // One tick per r_div+1 enabled cycles
    assign o_tick = i_en & (r_cnt == r_div);

endmodule

`default_nettype wire

/* hw/spi_shift_engine.sv */
`include "spi_settings.svh"
`default_nettype none

module spi_shift_engine (
    input  wire                     i_clk,
    input  wire                     i_rst,
    input  wire                     i_start,
    input  wire spi_pkg::spi_byte_t i_tx_byte,
    input  wire                     i_lsb_first,
    input  wire                     i_tick,
    input  wire                     i_spi_miso,
    output logic                    o_busy,
    output logic                    o_done,
    output spi_pkg::spi_byte_t      o_rx_byte,
    output logic                    o_spi_sck,
    output logic                    o_spi_mosi
);

    import spi_pkg::*;

    spi_byte_t r_tx_sh;
    spi_byte_t r_rx_sh;
    logic      r_lsb;
    logic      r_sck;
    logic      r_busy;
    logic      r_done;
    logic [$clog2(2*`SPI_DATA_W)-1:0] r_edge_cnt;

    function automatic spi_byte_t bit_rev(input spi_byte_t b);
        spi_byte_t r;
        for (int i = 0; i < `SPI_DATA_W; i++) begin
            r[i] = b[`SPI_DATA_W-1-i];
        end
        return r;
    endfunction

    // Shifter always sends from the top bit, LSB-first is reversed at load
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_busy     <= 1'b0;
            r_done     <= 1'b0;
            r_sck      <= 1'b0;
            r_lsb      <= 1'b0;
            r_edge_cnt <= '0;
            r_tx_sh    <= '0;
        end else begin
            r_done <= 1'b0;
            if (!r_busy) begin
                if (i_start) begin
                    r_busy     <= 1'b1;
                    r_lsb      <= i_lsb_first;
                    r_edge_cnt <= '0;
                    r_tx_sh    <= i_lsb_first ? bit_rev(i_tx_byte) : i_tx_byte;
                end
            end else if (i_tick) begin
                r_sck      <= ~r_sck;
                r_edge_cnt <= r_edge_cnt + 1'b1;
                if (r_sck) begin
                    r_tx_sh <= r_tx_sh << 1;   // Falling edge, next MOSI bit
                end
                if (r_edge_cnt == 2*`SPI_DATA_W-1) begin
                    r_busy <= 1'b0;   // Last falling edge
                    r_done <= 1'b1;
                end
            end
        end
    end

    // Wire order in, bit 0 is the last bit seen
    always_ff @(posedge i_clk) begin
        if (r_busy && i_tick && !r_sck) begin
            r_rx_sh <= {r_rx_sh[`SPI_DATA_W-2:0], i_spi_miso};
        end
    end

    assign o_rx_byte  = r_lsb ? bit_rev(r_rx_sh) : r_rx_sh;
    assign o_busy     = r_busy;
    assign o_done     = r_done;
    assign o_spi_sck  = r_sck;
    assign o_spi_mosi = r_tx_sh[`SPI_DATA_W-1];

endmodule

`default_nettype wire

/* hw/spi_master_top.sv */
`default_nettype none

module spi_master_top (
    input  wire                         i_clk,
    input  wire                         i_rst,

    input  wire                         i_psel,
    input  wire                         i_penable,
    input  wire                         i_pwrite,
    input  wire spi_pkg::spi_reg_addr_e i_paddr,
    input  wire spi_pkg::spi_byte_t     i_pwdata,
    output spi_pkg::spi_byte_t          o_prdata,
    output logic                        o_pready,
    output logic                        o_pslverr,

    output logic                        o_spi_cs_n,
    output logic                        o_spi_sck,
    output logic                        o_spi_mosi,
    input  wire                         i_spi_miso
);

    import spi_pkg::*;

    logic      start;
    logic      lsb_first;
    logic      busy;
    logic      done;
    logic      tick;
    spi_byte_t tx_byte;
    spi_byte_t rx_byte;
    spi_byte_t baud;

    spi_apb_regs u_regs (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_psel      (i_psel),
        .i_penable   (i_penable),
        .i_pwrite    (i_pwrite),
        .i_paddr     (i_paddr),
        .i_pwdata    (i_pwdata),
        .o_prdata    (o_prdata),
        .o_pready    (o_pready),
        .o_pslverr   (o_pslverr),
        .i_busy      (busy),
        .i_done      (done),
        .i_rx_byte   (rx_byte),
        .o_start     (start),
        .o_tx_byte   (tx_byte),
        .o_baud      (baud),
        .o_lsb_first (lsb_first),
        .o_cs_n      (o_spi_cs_n)
    );

    spi_clk_div u_div (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_en    (busy),   // Runs only during a transfer
        .i_start (start),
        .i_baud  (baud),
        .o_tick  (tick)
    );

    spi_shift_engine u_engine (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_start     (start),
        .i_tx_byte   (tx_byte),
        .i_lsb_first (lsb_first),
        .i_tick      (tick),
        .i_spi_miso  (i_spi_miso),
        .o_busy      (busy),
        .o_done      (done),
        .o_rx_byte   (rx_byte),
        .o_spi_sck   (o_spi_sck),
        .o_spi_mosi  (o_spi_mosi)
    );

endmodule

`default_nettype wire

/* sim/spi_slave_bfm.sv */
`include "spi_settings.svh"
`default_nettype none

module spi_slave_bfm (
    input  wire                     i_cs_n,
    input  wire                     i_sck,
    input  wire                     i_mosi,
    output logic                    o_miso,
    input  wire                     i_load,
    input  wire spi_pkg::spi_byte_t i_reply,
    input  wire                     i_lsb_first,
    output spi_pkg::spi_byte_t      o_wire_byte,
    output logic [3:0]              o_bit_count
);

    timeunit 1ns;
    timeprecision 1ps;

    import spi_pkg::*;

    spi_byte_t  r_out  = '0;
    spi_byte_t  r_wire = '0;
    logic [3:0] r_bits = '0;

    // Reply kept in wire order, first bit on top
    always @(posedge i_load or negedge i_sck) begin
        if (i_load) begin
            for (int i = 0; i < `SPI_DATA_W; i++) begin
                r_out[i] <= i_lsb_first ? i_reply[`SPI_DATA_W-1-i] : i_reply[i];
            end
        end else if (!i_cs_n) begin
            r_out <= r_out << 1;   // Next bit after falling SCK
        end
    end

    // MOSI recorded as seen on the wire, last bit in bit 0
    always @(posedge i_load or posedge i_sck) begin
        if (i_load) begin
            r_bits <= '0;
        end else if (!i_cs_n) begin
            r_wire <= {r_wire[`SPI_DATA_W-2:0], i_mosi};
            r_bits <= r_bits + 1'b1;
        end
    end

    assign o_miso      = i_cs_n ? 1'b0 : r_out[`SPI_DATA_W-1];   // Hold low when deselected
    assign o_wire_byte = r_wire;
    assign o_bit_count = r_bits;

endmodule

`default_nettype wire

/* sim/tb_spi_master.sv */
`include "spi_settings.svh"
`default_nettype none

module tb_spi_master;

    timeunit 1ns;
    timeprecision 1ps;

    import spi_pkg::*;

    localparam int APB_TIMEOUT = 300;   // Longest stall is 128 cycles
    localparam int POLL_LIMIT  = 200;

    logic          clk;
    logic          rst;
    logic          psel;
    logic          penable;
    logic          pwrite;
    spi_reg_addr_e paddr;
    spi_byte_t     pwdata;
    spi_byte_t     prdata;
    logic          pready;
    logic          pslverr;
    logic          spi_cs_n;
    logic          spi_sck;
    logic          spi_mosi;
    logic          spi_miso;
    logic          slave_load;
    spi_byte_t     slave_reply;
    logic          slave_lsb;
    spi_byte_t     slave_wire;
    logic [3:0]    slave_bits;

    integer        seed;
    int            errors;
    int            tests_run;
    int            tests_failed;
    int            test_start_errors;
    string         current_test;

    always #5 clk = ~clk;

    spi_master_top u_dut (
        .i_clk      (clk),
        .i_rst      (rst),
        .i_psel     (psel),
        .i_penable  (penable),
        .i_pwrite   (pwrite),
        .i_paddr    (paddr),
        .i_pwdata   (pwdata),
        .o_prdata   (prdata),
        .o_pready   (pready),
        .o_pslverr  (pslverr),
        .o_spi_cs_n (spi_cs_n),
        .o_spi_sck  (spi_sck),
        .o_spi_mosi (spi_mosi),
        .i_spi_miso (spi_miso)
    );

    spi_slave_bfm u_slave (
        .i_cs_n      (spi_cs_n),
        .i_sck       (spi_sck),
        .i_mosi      (spi_mosi),
        .o_miso      (spi_miso),
        .i_load      (slave_load),
        .i_reply     (slave_reply),
        .i_lsb_first (slave_lsb),
        .o_wire_byte (slave_wire),
        .o_bit_count (slave_bits)
    );

    function automatic spi_byte_t reverse_bits(input spi_byte_t b);
        spi_byte_t r;
        for (int i = 0; i < `SPI_DATA_W; i++) begin
            r[i] = b[`SPI_DATA_W-1-i];
        end
        return r;
    endfunction

    task automatic check_byte(input spi_byte_t actual, input spi_byte_t expected,
                              input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0d ns: %s is %02h, expected %02h",
                     $time, what, actual, expected);
            errors++;
        end
    endtask

    task automatic check_status(input spi_ctrl_word_u actual, input spi_ctrl_word_u expected,
                                input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0d ns: %s is %02h (busy %0b), expected %02h",
                     $time, what, actual, actual.status.busy, expected);
            errors++;
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0d ns: %s is %0b, expected %0b",
                     $time, what, actual, expected);
            errors++;
        end
    endtask

    task automatic start_test(input string name);
        current_test      = name;
        test_start_errors = errors;
    endtask

    task automatic finish_test();
        tests_run++;
        if (errors != test_start_errors) begin
            tests_failed++;
        end
        $display("test %s %s", current_test,
                 (errors == test_start_errors) ? "ok" : "mismatches");
    endtask

    // One APB transfer with setup and access phases until PREADY
    task automatic apb_access(input logic write, input spi_reg_addr_e addr,
                              input spi_byte_t wdata, output spi_byte_t rdata,
                              output logic err, output int waits);
        logic complete;
        complete = 1'b0;
        waits    = 0;
        rdata    = '0;
        err      = 1'b0;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        while (!complete && waits < APB_TIMEOUT) begin
            @(negedge clk);
            if (pready) begin
                rdata    = prdata;
                err      = pslverr;
                complete = 1'b1;
            end else begin
                waits++;
            end
        end
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        if (!complete) begin
            $display("Error at %0d ns: APB access to %s got no PREADY within %0d cycles",
                     $time, addr.name(), APB_TIMEOUT);
            errors++;
        end
    endtask

    task automatic apb_write(input spi_reg_addr_e addr, input spi_byte_t data, output logic err);
        spi_byte_t rd;
        int        waits;
        apb_access(1'b1, addr, data, rd, err, waits);
    endtask

    task automatic apb_read(input spi_reg_addr_e addr, output spi_byte_t data);
        logic err;
        int   waits;
        apb_access(1'b0, addr, '0, data, err, waits);
    endtask

    task automatic wait_idle();
        spi_byte_t      rd;
        spi_ctrl_word_u st;
        int             polls;
        logic           idle;
        polls = 0;
        idle  = 1'b0;
        while (!idle && polls < POLL_LIMIT) begin
            apb_read(REG_CTRL, rd);
            st = rd;
            if (!st.status.busy) begin
                idle = 1'b1;
            end else begin
                polls++;
            end
        end
        if (!idle) begin
            $display("Error at %0d ns: busy did not clear within %0d status reads",
                     $time, POLL_LIMIT);
            errors++;
        end
    endtask

    task automatic load_slave(input spi_byte_t reply, input logic lsb);
        @(posedge clk);
        slave_reply <= reply;
        slave_lsb   <= lsb;
        @(posedge clk);
        slave_load <= 1'b1;
        @(posedge clk);
        slave_load <= 1'b0;
    endtask

    task automatic run_transfer(input spi_byte_t tx, input spi_byte_t reply, input logic lsb,
                                input string tag);
        spi_byte_t wire_tx;
        spi_byte_t wire_reply;
        spi_byte_t rx;
        logic      err;
        wire_tx    = lsb ? reverse_bits(tx) : tx;      // First bit at the top
        wire_reply = lsb ? reverse_bits(reply) : reply;
        load_slave(reply, lsb);
        apb_write(REG_TXDATA, tx, err);
        wait_idle();
        check_byte(slave_wire, wire_tx, {tag, " MOSI byte"});
        check_byte(spi_byte_t'(slave_bits), 8'd8, {tag, " SCK rising edges"});
        apb_read(REG_RXDATA, rx);
        check_byte(rx, lsb ? reverse_bits(wire_reply) : wire_reply, {tag, " RXDATA"});
    endtask

    initial begin
        spi_byte_t      rd;
        spi_byte_t      data;
        spi_byte_t      prev;
        spi_byte_t      tx;
        spi_byte_t      reply;
        spi_byte_t      tx2;
        spi_byte_t      reply2;
        spi_ctrl_word_u wr_word;
        spi_ctrl_word_u exp_word;
        spi_ctrl_word_u rd_word;
        logic           err;
        int             waits;

        seed         = 32'he67b197f;
        clk          = 1'b0;
        rst          = 1'b1;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = REG_BAUD;
        pwdata       = '0;
        slave_load   = 1'b0;
        slave_reply  = '0;
        slave_lsb    = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        start_test("reset");
        @(negedge clk);
        check_flag(spi_cs_n, 1'b1, "o_spi_cs_n after reset");
        check_flag(spi_sck, 1'b0, "o_spi_sck after reset");
        check_flag(pready, 1'b1, "o_pready after reset");
        check_flag(pslverr, 1'b0, "o_pslverr after reset");
        apb_read(REG_BAUD, rd);
        check_byte(rd, `SPI_DIV_RESET, "BAUD after reset");
        apb_read(REG_CTRL, rd);
        rd_word = rd;
        check_status(rd_word, '0, "status after reset");
        apb_read(REG_RXDATA, rd);
        check_byte(rd, 8'h00, "RXDATA after reset");
        finish_test();

        start_test("readback");
        for (int n = 0; n < 12; n++) begin
            data = spi_byte_t'($random(seed));
            apb_write(REG_BAUD, data, err);
            check_flag(err, 1'b0, "o_pslverr on BAUD write");
            apb_read(REG_BAUD, rd);
            check_byte(rd, data, "BAUD readback");
            wr_word = spi_byte_t'($random(seed));
            apb_write(REG_CTRL, wr_word, err);
            apb_read(REG_CTRL, rd);
            rd_word  = rd;
            exp_word = '0;   // Busy and reserved bits read 0
            exp_word.status.cs_en     = wr_word.ctrl.cs_en;
            exp_word.status.lsb_first = wr_word.ctrl.lsb_first;
            check_status(rd_word, exp_word, "CTRL readback");
            @(negedge clk);
            check_flag(spi_cs_n, ~wr_word.ctrl.cs_en, "o_spi_cs_n against cs_en");
        end
        finish_test();

        start_test("msb_first");
        wr_word = '0;
        wr_word.ctrl.cs_en = 1'b1;
        apb_write(REG_CTRL, wr_word, err);
        for (int n = 0; n < 40; n++) begin
            data = spi_byte_t'($random(seed)) & 8'h07;
            apb_write(REG_BAUD, data, err);
            tx    = spi_byte_t'($random(seed));
            reply = spi_byte_t'($random(seed));
            run_transfer(tx, reply, 1'b0, $sformatf("msb transfer %0d", n));
        end
        finish_test();

        start_test("lsb_first");
        wr_word.ctrl.lsb_first = 1'b1;
        apb_write(REG_CTRL, wr_word, err);
        for (int n = 0; n < 24; n++) begin
            data = spi_byte_t'($random(seed)) & 8'h07;
            apb_write(REG_BAUD, data, err);
            tx    = spi_byte_t'($random(seed));
            reply = spi_byte_t'($random(seed));
            run_transfer(tx, reply, 1'b1, $sformatf("lsb transfer %0d", n));
        end
        finish_test();

        start_test("backpressure");
        wr_word.ctrl.lsb_first = 1'b0;
        apb_write(REG_CTRL, wr_word, err);
        apb_write(REG_BAUD, 8'd3, err);
        tx     = spi_byte_t'($random(seed));
        reply  = spi_byte_t'($random(seed));
        tx2    = spi_byte_t'($random(seed));
        reply2 = spi_byte_t'($random(seed));
        load_slave(reply, 1'b0);
        apb_write(REG_TXDATA, tx, err);
        apb_access(1'b1, REG_TXDATA, tx2, rd, err, waits);
        check_flag(waits != 0, 1'b1, "o_pready low during TXDATA write while busy");
        // First transfer fully out before the stalled write completed
        check_byte(slave_wire, tx, "first byte on MOSI");
        check_byte(spi_byte_t'(slave_bits), 8'd8, "SCK rising edges of first byte");
        check_flag(spi_sck, 1'b0, "o_spi_sck when stalled write completes");
        load_slave(reply2, 1'b0);
        apb_read(REG_RXDATA, rd);
        check_byte(rd, reply, "RXDATA of first byte");
        wait_idle();
        check_byte(slave_wire, tx2, "second byte on MOSI");
        apb_read(REG_RXDATA, rd);
        check_byte(rd, reply2, "RXDATA of second byte");
        finish_test();

        start_test("slverr");
        apb_read(REG_RXDATA, prev);
        data = prev ^ (spi_byte_t'($random(seed)) | 8'h01);   // Never equal to RXDATA
        apb_write(REG_RXDATA, data, err);
        check_flag(err, 1'b1, "o_pslverr on RXDATA write");
        apb_read(REG_RXDATA, rd);
        check_byte(rd, prev, "RXDATA after rejected write");
        apb_write(REG_BAUD, 8'd2, err);
        check_flag(err, 1'b0, "o_pslverr on BAUD write");
        finish_test();

        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+hw
hw/spi_pkg.sv
hw/spi_apb_regs.sv
hw/spi_clk_div.sv
hw/spi_shift_engine.sv
hw/spi_master_top.sv
sim/spi_slave_bfm.sv
sim/tb_spi_master.sv
